// File: Makefile
TOP = tbRasterix

.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP)

run:
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: all.f
rasterPkg.sv
bufferCtrlIf.sv
commandParser.sv
rasterizer.sv
colorBuffer.sv
rasterix.sv
rasterChecker.sv
tbRasterix.sv

// File: bufferCtrlIf.sv
////////////////////////////////////////////////////////////
// Buffer command handshake between parser and color buffer.
// apply is a level held until the one-cycle applied pulse.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface bufferCtrlIf;
    import rasterPkg::*;

    logic apply;
    logic applied;
    logic cmdMemset;
    logic cmdCommit;
    colorT clearColor;

    // Command side
    modport ctrl (
        output apply,
        output cmdMemset,
        output cmdCommit,
        output clearColor,
        input applied
    );

    // Memory side
    modport mem (
        input apply,
        input cmdMemset,
        input cmdCommit,
        input clearColor,
        output applied
    );

endinterface

// File: colorBuffer.sv
////////////////////////////////////////////////////////////
// Color frame buffer with one write port.
// Fragments must not arrive during a memset or a commit.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module colorBuffer (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  fragValid,
    input  rasterPkg::pixelIndexT fragIndex,
    input  rasterPkg::colorT      fragColor,
    bufferCtrlIf.mem              bufCtrl,
    output logic                  fbAxisTvalid,
    input  logic                  fbAxisTready,
    output logic                  fbAxisTlast,
    output rasterPkg::colorT      fbAxisTdata
);
    import rasterPkg::*;

    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_MEMSET,
        BUF_COMMIT
    } bufStateT;

    bufStateT state;
    colorT mem [FRAME_SIZE];
    pixelIndexT cnt;
    logic lastIndex;
    logic loadBeat;
    logic beatDone;
    logic wrEn;
    pixelIndexT wrAddr;
    colorT wrData;

    assign lastIndex = (cnt == pixelIndexT'(FRAME_SIZE - 1));

    // Refill the output register when empty or drained, stop after tlast
    assign loadBeat = (state == BUF_COMMIT) && !(fbAxisTvalid && fbAxisTlast)
                      && (!fbAxisTvalid || fbAxisTready);
    assign beatDone = fbAxisTvalid && fbAxisTready && fbAxisTlast;

    ////////////////////////////////////////////////////////////
    // Write port shared by memset and fragments
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (state == BUF_MEMSET) begin
            wrEn = 1'b1;
            wrAddr = cnt;
            wrData = bufCtrl.clearColor;
        end else begin
            wrEn = fragValid;
            wrAddr = fragIndex;
            wrData = fragColor;
        end
    end

    always_ff @(posedge aclk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Output data register, held while the sink stalls
    always_ff @(posedge aclk) begin
        if (loadBeat) begin
            fbAxisTdata <= mem[cnt];
        end
    end

    ////////////////////////////////////////////////////////////
    // Sweep control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= BUF_IDLE;
            cnt <= '0;
            bufCtrl.applied <= 1'b0;
            fbAxisTvalid <= 1'b0;
            fbAxisTlast <= 1'b0;
        end else begin
            bufCtrl.applied <= 1'b0;
            case (state)
                BUF_IDLE: begin
                    // apply is still high in the applied cycle
                    if (bufCtrl.apply && !bufCtrl.applied) begin
                        cnt <= '0;
                        if (bufCtrl.cmdMemset) begin
                            state <= BUF_MEMSET;
                        end else if (bufCtrl.cmdCommit) begin
                            state <= BUF_COMMIT;
                        end else begin
                            bufCtrl.applied <= 1'b1;
                        end
                    end
                end
                BUF_MEMSET: begin
                    cnt <= cnt + pixelIndexT'(1);
                    if (lastIndex) begin
                        bufCtrl.applied <= 1'b1;
                        state <= BUF_IDLE;
                    end
                end
                BUF_COMMIT: begin
                    if (loadBeat) begin
                        fbAxisTvalid <= 1'b1;
                        fbAxisTlast <= lastIndex;
                        cnt <= cnt + pixelIndexT'(1);
                    end else if (beatDone) begin
                        fbAxisTvalid <= 1'b0;
                        fbAxisTlast <= 1'b0;
                        bufCtrl.applied <= 1'b1;
                        state <= BUF_IDLE;
                    end
                end
                default: begin
                    state <= BUF_IDLE;
                end
            endcase
        end
    end

endmodule

// File: commandParser.sv
////////////////////////////////////////////////////////////
// Decodes the command stream, one word per cycle.
// Stream is blocked until the running command completes.
// Unknown opcodes consume a single word and are ignored.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module commandParser (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         cmdAxisTvalid,
    output logic                         cmdAxisTready,
    input  logic [rasterPkg::CMD_WIDTH-1:0] cmdAxisTdata,
    output rasterPkg::triangleParamsT    params,
    output logic                         startRendering,
    input  logic                         rasterizerRunning,
    bufferCtrlIf.ctrl                    bufCtrl
);
    import rasterPkg::*;

    typedef enum logic [2:0] {
        PARSE_IDLE,
        PARSE_PARAMS,
        PARSE_CLEAR,
        WAIT_RASTER,
        WAIT_BUFFER
    } parseStateT;

    parseStateT state;
    logic [3:0] paramCnt;
    logic [3:0] opcode;
    logic wordAccepted;

    assign opcode = cmdAxisTdata[CMD_WIDTH-1 -: 4];
    assign wordAccepted = cmdAxisTvalid && cmdAxisTready;

    // Ready only while a command is still being read
    assign cmdAxisTready = (state == PARSE_IDLE) || (state == PARSE_PARAMS)
                           || (state == PARSE_CLEAR);

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= PARSE_IDLE;
            paramCnt <= '0;
            startRendering <= 1'b0;
            bufCtrl.apply <= 1'b0;
            bufCtrl.cmdMemset <= 1'b0;
            bufCtrl.cmdCommit <= 1'b0;
        end else begin
            startRendering <= 1'b0;
            case (state)
                PARSE_IDLE: begin
                    if (wordAccepted) begin
                        case (opcode)
                            OP_TRIANGLE: begin
                                paramCnt <= '0;
                                state <= PARSE_PARAMS;
                            end
                            OP_CLEAR: begin
                                state <= PARSE_CLEAR;
                            end
                            // Commit has no payload, issue it right away
                            OP_COMMIT: begin
                                bufCtrl.apply <= 1'b1;
                                bufCtrl.cmdCommit <= 1'b1;
                                bufCtrl.cmdMemset <= 1'b0;
                                state <= WAIT_BUFFER;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                PARSE_PARAMS: begin
                    if (wordAccepted) begin
                        paramCnt <= paramCnt + 4'd1;
                        if (paramCnt == 4'(PARAM_WORDS - 1)) begin
                            startRendering <= 1'b1;
                            state <= WAIT_RASTER;
                        end
                    end
                end
                PARSE_CLEAR: begin
                    if (wordAccepted) begin
                        bufCtrl.apply <= 1'b1;
                        bufCtrl.cmdMemset <= 1'b1;
                        bufCtrl.cmdCommit <= 1'b0;
                        state <= WAIT_BUFFER;
                    end
                end
                WAIT_RASTER: begin
                    // Running rises one cycle after the start pulse
                    if (!startRendering && !rasterizerRunning) begin
                        state <= PARSE_IDLE;
                    end
                end
                WAIT_BUFFER: begin
                    if (bufCtrl.applied) begin
                        bufCtrl.apply <= 1'b0;
                        bufCtrl.cmdMemset <= 1'b0;
                        bufCtrl.cmdCommit <= 1'b0;
                        state <= PARSE_IDLE;
                    end
                end
                default: begin
                    state <= PARSE_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Payload capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wordAccepted && (state == PARSE_PARAMS)) begin
            params <= {params[PARAMS_WIDTH-CMD_WIDTH-1:0], cmdAxisTdata};
        end
        if (wordAccepted && (state == PARSE_CLEAR)) begin
            bufCtrl.clearColor <= cmdAxisTdata;
        end
    end

endmodule

// File: rasterChecker.sv
////////////////////////////////////////////////////////////
// Watches the frame stream and compares it with the model.
// One commit is checked at a time, between arm and close.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rasterChecker (
    input  logic             aclk,
    input  logic             cmdAxisTready,
    input  logic             dbgRasterizerRunning,
    input  logic             fbAxisTvalid,
    input  logic             fbAxisTready,
    input  logic             fbAxisTlast,
    input  rasterPkg::colorT fbAxisTdata,
    input  rasterPkg::colorT expImage [rasterPkg::FRAME_SIZE],
    output int               errorCount,
    output int               testCount,
    output int               failCount
);
    import rasterPkg::*;

    string testName = "none";
    logic armed = 1'b0;
    int beatTotal = 0;
    int errTotal = 0;
    int startBeat = 0;
    int startErrors = 0;
    int extraErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int idx;

    assign errorCount = errTotal + extraErrors;
    assign testCount = testsRun;
    assign failCount = testsFailed;

    ////////////////////////////////////////////////////////////
    // Beat sampling
    ////////////////////////////////////////////////////////////
    always @(posedge aclk) begin
        if (fbAxisTvalid && fbAxisTready) begin
            idx = beatTotal - startBeat;
            if (!armed) begin
                $display("Output beat seen while no commit was running");
                errTotal = errTotal + 1;
            end else if (idx >= FRAME_SIZE) begin
                $display("%s: more than %0d beats in one commit", testName, FRAME_SIZE);
                errTotal = errTotal + 1;
            end else begin
                if (fbAxisTdata !== expImage[pixelIndexT'(idx)]) begin
                    $display("ERROR %s pixel %0d expected %h actual %h", testName, idx,
                             expImage[pixelIndexT'(idx)], fbAxisTdata);
                    errTotal = errTotal + 1;
                end
                // tlast belongs to the final pixel only
                if (fbAxisTlast !== (idx == FRAME_SIZE - 1)) begin
                    $display("ERROR %s tlast at pixel %0d expected %b actual %b", testName,
                             idx, (idx == FRAME_SIZE - 1), fbAxisTlast);
                    errTotal = errTotal + 1;
                end
            end
            beatTotal = beatTotal + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test bookkeeping, called from the testbench top
    ////////////////////////////////////////////////////////////
    task automatic reportTest(input int errs);
        testsRun = testsRun + 1;
        if (errs == 0) begin
            $display("%s: ok", testName);
        end else begin
            testsFailed = testsFailed + 1;
            $display("%s: %0d errors", testName, errs);
        end
    endtask

    task automatic armCommit(input string name);
        testName = name;
        startBeat = beatTotal;
        startErrors = errTotal;
        armed = 1'b1;
    endtask

    task automatic closeCommit();
        int beats;
        int errs;
        beats = beatTotal - startBeat;
        errs = errTotal - startErrors;
        if (beats != FRAME_SIZE) begin
            $display("%s: commit ended after %0d beats instead of %0d", testName, beats,
                     FRAME_SIZE);
            errs = errs + 1;
            extraErrors = extraErrors + 1;
        end
        armed = 1'b0;
        reportTest(errs);
    endtask

    task automatic checkReset(input string name);
        int errs;
        errs = 0;
        testName = name;
        if (cmdAxisTready !== 1'b1) begin
            $display("ERROR %s cmdAxisTready expected 1 actual %b", name, cmdAxisTready);
            errs = errs + 1;
        end
        if (fbAxisTvalid !== 1'b0) begin
            $display("ERROR %s fbAxisTvalid expected 0 actual %b", name, fbAxisTvalid);
            errs = errs + 1;
        end
        if (dbgRasterizerRunning !== 1'b0) begin
            $display("ERROR %s dbgRasterizerRunning expected 0 actual %b", name,
                     dbgRasterizerRunning);
            errs = errs + 1;
        end
        extraErrors = extraErrors + errs;
        reportTest(errs);
    endtask

endmodule

// File: rasterPkg.sv
////////////////////////////////////////////////////////////
// Shared sizes, opcodes and types of the tile rasterizer.
// Screen is fixed at 16 x 16 pixels, color is RGBA4444.
////////////////////////////////////////////////////////////

package rasterPkg;

    ////////////////////////////////////////////////////////////
    // Screen geometry
    ////////////////////////////////////////////////////////////
    localparam int X_RESOLUTION = 16;
    localparam int Y_RESOLUTION = 16;
    localparam int FRAME_SIZE = X_RESOLUTION * Y_RESOLUTION;
    localparam int INDEX_WIDTH = $clog2(FRAME_SIZE);

    ////////////////////////////////////////////////////////////
    // Command stream
    ////////////////////////////////////////////////////////////
    localparam int CMD_WIDTH = 16;
    localparam int PARAM_WORDS = 12;
    localparam int PARAMS_WIDTH = PARAM_WORDS * CMD_WIDTH;

    // Opcode sits in the top nibble of a header word
    localparam logic [3:0] OP_CLEAR = 4'd1;
    localparam logic [3:0] OP_TRIANGLE = 4'd2;
    localparam logic [3:0] OP_COMMIT = 4'd3;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////
    typedef logic [15:0] colorT;
    typedef logic [INDEX_WIDTH-1:0] pixelIndexT;
    typedef logic [3:0] coordT;
    typedef logic signed [15:0] edgeT;

    // Members in stream order, first word lands in the MSBs
    typedef struct packed {
        logic [15:0] bbStart;
        logic [15:0] bbEnd;
        edgeT w0;
        edgeT w1;
        edgeT w2;
        edgeT w0IncX;
        edgeT w1IncX;
        edgeT w2IncX;
        edgeT w0IncY;
        edgeT w1IncY;
        edgeT w2IncY;
        colorT color;
    } triangleParamsT;

endpackage

// File: rasterix.sv
////////////////////////////////////////////////////////////
// Top level of the 16 x 16 tile rasterizer.
// Commands run strictly one after another.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rasterix (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            cmdAxisTvalid,
    output logic                            cmdAxisTready,
    input  logic [rasterPkg::CMD_WIDTH-1:0] cmdAxisTdata,
    output logic                            fbAxisTvalid,
    input  logic                            fbAxisTready,
    output logic                            fbAxisTlast,
    output rasterPkg::colorT                fbAxisTdata,
    output logic                            dbgRasterizerRunning
);
    import rasterPkg::*;

    triangleParamsT params;
    logic startRendering;
    logic rasterizerRunning;
    logic fragValid;
    pixelIndexT fragIndex;
    colorT fragColor;

    bufferCtrlIf bufCtrl ();

    assign dbgRasterizerRunning = rasterizerRunning;

    commandParser parser (
        .aclk(aclk),
        .rst(rst),
        .cmdAxisTvalid(cmdAxisTvalid),
        .cmdAxisTready(cmdAxisTready),
        .cmdAxisTdata(cmdAxisTdata),
        .params(params),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .bufCtrl(bufCtrl.ctrl)
    );

    rasterizer rop (
        .aclk(aclk),
        .rst(rst),
        .params(params),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .fragValid(fragValid),
        .fragIndex(fragIndex),
        .fragColor(fragColor)
    );

    colorBuffer frameBuffer (
        .aclk(aclk),
        .rst(rst),
        .fragValid(fragValid),
        .fragIndex(fragIndex),
        .fragColor(fragColor),
        .bufCtrl(bufCtrl.mem),
        .fbAxisTvalid(fbAxisTvalid),
        .fbAxisTready(fbAxisTready),
        .fbAxisTlast(fbAxisTlast),
        .fbAxisTdata(fbAxisTdata)
    );

endmodule

// File: rasterizer.sv
////////////////////////////////////////////////////////////
// Edge-function rasterizer, one pixel per cycle.
// Walks the bounding box row by row, box must lie on screen.
// Edge sums wrap modulo 2^16, no overflow detection.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rasterizer (
    input  logic                      aclk,
    input  logic                      rst,
    input  rasterPkg::triangleParamsT params,
    input  logic                      startRendering,
    output logic                      rasterizerRunning,
    output logic                      fragValid,
    output rasterPkg::pixelIndexT     fragIndex,
    output rasterPkg::colorT          fragColor
);
    import rasterPkg::*;

    coordT bbStartX;
    coordT bbStartY;
    coordT bbEndX;
    coordT bbEndY;
    coordT xPos;
    coordT yPos;
    logic lastCol;
    logic lastRow;
    logic covered;

    edgeT wInit [3];
    edgeT incX [3];
    edgeT incY [3];
    edgeT edgeVal [3];
    edgeT rowVal [3];

    // x in the low nibble, y in bits 11..8
    assign bbStartX = params.bbStart[3:0];
    assign bbStartY = params.bbStart[11:8];
    assign bbEndX = params.bbEnd[3:0];
    assign bbEndY = params.bbEnd[11:8];

    assign wInit[0] = params.w0;
    assign wInit[1] = params.w1;
    assign wInit[2] = params.w2;
    assign incX[0] = params.w0IncX;
    assign incX[1] = params.w1IncX;
    assign incX[2] = params.w2IncX;
    assign incY[0] = params.w0IncY;
    assign incY[1] = params.w1IncY;
    assign incY[2] = params.w2IncY;

    assign lastCol = (xPos == bbEndX);
    assign lastRow = (yPos == bbEndY);

    // Inside when no edge value is negative
    assign covered = !edgeVal[0][15] && !edgeVal[1][15] && !edgeVal[2][15];

    ////////////////////////////////////////////////////////////
    // Fragment output for the pixel under test
    ////////////////////////////////////////////////////////////
    assign fragValid = rasterizerRunning && covered;
    assign fragIndex = pixelIndexT'(yPos) * pixelIndexT'(X_RESOLUTION) + pixelIndexT'(xPos);
    assign fragColor = params.color;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rasterizerRunning <= 1'b0;
        end else if (startRendering) begin
            rasterizerRunning <= 1'b1;
        end else if (rasterizerRunning && lastCol && lastRow) begin
            rasterizerRunning <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Box walk and edge stepping
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (startRendering) begin
            xPos <= bbStartX;
            yPos <= bbStartY;
            for (int i = 0; i < 3; i++) begin
                edgeVal[i] <= wInit[i];
                rowVal[i] <= wInit[i];
            end
        end else if (rasterizerRunning) begin
            if (lastCol) begin
                // New row starts from the saved row-start values
                xPos <= bbStartX;
                yPos <= yPos + coordT'(1);
                for (int i = 0; i < 3; i++) begin
                    edgeVal[i] <= rowVal[i] + incY[i];
                    rowVal[i] <= rowVal[i] + incY[i];
                end
            end else begin
                xPos <= xPos + coordT'(1);
                for (int i = 0; i < 3; i++) begin
                    edgeVal[i] <= edgeVal[i] + incX[i];
                end
            end
        end
    end

endmodule

// File: tbRasterix.sv
////////////////////////////////////////////////////////////
// Testbench for the tile rasterizer, with a reference image.
// Commands are sent one at a time, each waits for completion.
// Frame contents before the first clear are not checked.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tbRasterix;
    import rasterPkg::*;

    // Words 80, clears and commits 10, triangles 5 over all tests
    localparam int WORD_COUNT = 80;
    localparam int BUFFER_OPS = 10;
    localparam int TRIANGLES = 5;
    localparam int TIMEOUT_CYCLES = (WORD_COUNT * 300 + BUFFER_OPS * 300
                                     + TRIANGLES * 300) * 2 + 5;

    logic aclk = 1'b0;
    logic rst = 1'b1;
    logic cmdAxisTvalid = 1'b0;
    logic [CMD_WIDTH-1:0] cmdAxisTdata = '0;
    logic fbAxisTready = 1'b1;
    logic cmdAxisTready;
    logic fbAxisTvalid;
    logic fbAxisTlast;
    colorT fbAxisTdata;
    logic dbgRasterizerRunning;

    logic randomReady = 1'b0;
    integer seed = 51950;
    colorT modelImage [FRAME_SIZE];
    logic [15:0] triWords [PARAM_WORDS];
    int errorCount;
    int testCount;
    int failCount;

    always #10 aclk = ~aclk;

    rasterix DUT (
        .aclk(aclk),
        .rst(rst),
        .cmdAxisTvalid(cmdAxisTvalid),
        .cmdAxisTready(cmdAxisTready),
        .cmdAxisTdata(cmdAxisTdata),
        .fbAxisTvalid(fbAxisTvalid),
        .fbAxisTready(fbAxisTready),
        .fbAxisTlast(fbAxisTlast),
        .fbAxisTdata(fbAxisTdata),
        .dbgRasterizerRunning(dbgRasterizerRunning)
    );

    rasterChecker frameCheck (
        .aclk(aclk),
        .cmdAxisTready(cmdAxisTready),
        .dbgRasterizerRunning(dbgRasterizerRunning),
        .fbAxisTvalid(fbAxisTvalid),
        .fbAxisTready(fbAxisTready),
        .fbAxisTlast(fbAxisTlast),
        .fbAxisTdata(fbAxisTdata),
        .expImage(modelImage),
        .errorCount(errorCount),
        .testCount(testCount),
        .failCount(failCount)
    );

    // Sink stalls about one beat in four when enabled
    always @(negedge aclk) begin
        fbAxisTready = randomReady ? (($random(seed) % 4) != 0) : 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Reference image model
    ////////////////////////////////////////////////////////////
    function automatic void applyToModel(input logic [3:0] op, input logic [15:0] p [12]);
        int sx;
        int sy;
        int ex;
        int ey;
        int e;
        logic covered;
        if (op == OP_CLEAR) begin
            for (int i = 0; i < FRAME_SIZE; i++) begin
                modelImage[pixelIndexT'(i)] = p[0];
            end
        end else if (op == OP_TRIANGLE) begin
            sx = int'(p[0][3:0]);
            sy = int'(p[0][11:8]);
            ex = int'(p[1][3:0]);
            ey = int'(p[1][11:8]);
            for (int y = sy; y <= ey; y++) begin
                for (int x = sx; x <= ex; x++) begin
                    covered = 1'b1;
                    // Bit 15 of the sum is the sign of the 16-bit wrapped value
                    for (int k = 0; k < 3; k++) begin
                        e = int'($signed(p[2+k])) + (x - sx) * int'($signed(p[5+k]))
                            + (y - sy) * int'($signed(p[8+k]));
                        if (e[15]) begin
                            covered = 1'b0;
                        end
                    end
                    if (covered) begin
                        modelImage[pixelIndexT'(y * X_RESOLUTION + x)] = p[11];
                    end
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Command stimulus, called at a falling edge
    ////////////////////////////////////////////////////////////
    task automatic sendWord(input logic [15:0] w);
        while (!cmdAxisTready) @(negedge aclk);
        cmdAxisTvalid = 1'b1;
        cmdAxisTdata = w;
        @(negedge aclk);
        cmdAxisTvalid = 1'b0;
    endtask

    task automatic waitIdle();
        while (!cmdAxisTready) @(negedge aclk);
    endtask

    task automatic clearScreen(input colorT color);
        logic [15:0] p [12];
        p = '{default: 16'h0000};
        p[0] = color;
        sendWord({OP_CLEAR, 12'h000});
        sendWord(color);
        waitIdle();
        applyToModel(OP_CLEAR, p);
    endtask

    task automatic drawTriangle(input logic [15:0] p [12]);
        sendWord({OP_TRIANGLE, 12'h000});
        for (int i = 0; i < PARAM_WORDS; i++) begin
            sendWord(p[i]);
        end
        waitIdle();
        applyToModel(OP_TRIANGLE, p);
    endtask

    task automatic commitFrame(input string name);
        frameCheck.armCommit(name);
        sendWord({OP_COMMIT, 12'h000});
        waitIdle();
        frameCheck.closeCommit();
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        @(negedge aclk);
        frameCheck.checkReset("reset");

        clearScreen(16'h48C0);
        commitFrame("clearCommit");

        // Order: bbStart bbEnd w0 w1 w2 incX0..2 incY0..2 color
        clearScreen(16'h0000);
        triWords = '{16'h0102, 16'h0E0D, 16'd0, 16'd0, 16'd20, 16'd2, -16'd1, -16'd1,
                     -16'd1, 16'd2, -16'd1, 16'h0F0F};
        drawTriangle(triWords);
        commitFrame("oneTriangle");

        clearScreen(16'h1111);
        triWords = '{16'h0000, 16'h0F0F, 16'd0, 16'd0, 16'd15, 16'd1, 16'd0, -16'd1,
                     16'd0, 16'd1, -16'd1, 16'hF00F};
        drawTriangle(triWords);
        triWords = '{16'h0404, 16'h0F0F, 16'd0, 16'd0, 16'd1400, 16'd1, 16'd0, -16'd100,
                     16'd0, 16'd1, -16'd100, 16'h0FF0};
        drawTriangle(triWords);
        commitFrame("overlap");

        clearScreen(16'h2222);
        triWords = '{16'h0605, 16'h0809, 16'd100, 16'd100, 16'd100, 16'd1, 16'd1, 16'd1,
                     16'd1, 16'd1, 16'd1, 16'hABCD};
        drawTriangle(triWords);
        commitFrame("clipping");

        // w0 wraps negative and back to positive along each row
        clearScreen(16'h3333);
        triWords = '{16'h0000, 16'h0F0F, 16'd30000, 16'd0, 16'd200, 16'd5000, 16'd0,
                     -16'd10, 16'd0, 16'd1, -16'd10, 16'h5A5A};
        drawTriangle(triWords);
        randomReady = 1'b1;
        commitFrame("backPressure");
        randomReady = 1'b0;

        @(negedge aclk);
        $display("Tests run %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
        if (errorCount == 0 && failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule
